//--- hdl/xbar_params.svh
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// ---------------------------------------------------------------------------
// port counts and memory map size
// ---------------------------------------------------------------------------
`define XBAR_N_TARG       2                        // upstream masters
`define XBAR_N_INIT       2                        // downstream slaves
`define XBAR_N_REGION     2                        // map rules per initiator port

// ---------------------------------------------------------------------------
// channel widths
// ---------------------------------------------------------------------------
`define XBAR_ADDR_W       32
`define XBAR_DATA_W       64
`define XBAR_ID_IN_W      4                        // id width at the target ports
`define XBAR_ID_OUT_W     (`XBAR_ID_IN_W + 1)      // one extra bit for target index
`define XBAR_LEN_W        8                        // arlen, beats minus one

`define XBAR_RESP_OKAY    2'b00
`define XBAR_RESP_DECERR  2'b11

`endif

//--- hdl/xbar_pkg.sv
package xbar_pkg;

`include "xbar_params.svh"

  // ---------------------------------------------------------------------------
  // read address channel payloads
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [`XBAR_ID_IN_W-1:0]  id;                 // id as issued by the master
    logic [`XBAR_ADDR_W-1:0]   addr;
    logic [`XBAR_LEN_W-1:0]    len;                // beats minus one
  } ar_in_t;

  typedef struct packed {
    logic [`XBAR_ID_OUT_W-1:0] id;                 // {target index, master id}
    logic [`XBAR_ADDR_W-1:0]   addr;
    logic [`XBAR_LEN_W-1:0]    len;
  } ar_out_t;

  // ---------------------------------------------------------------------------
  // read data channel payloads
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [`XBAR_ID_OUT_W-1:0] id;                 // upper bit routes the beat back
    logic [`XBAR_DATA_W-1:0]   data;
    logic [1:0]                resp;
    logic                      last;
  } r_out_t;

  typedef struct packed {
    logic [`XBAR_ID_IN_W-1:0]  id;
    logic [`XBAR_DATA_W-1:0]   data;
    logic [1:0]                resp;
    logic                      last;
  } r_in_t;

  // one address window of the memory map, bounds inclusive
  typedef struct packed {
    logic [`XBAR_ADDR_W-1:0]   start_addr;
    logic [`XBAR_ADDR_W-1:0]   end_addr;
    logic                      enable;
  } map_rule_t;

endpackage

//--- hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter
#(
  parameter int N_REQ = 2
)
(
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  logic [N_REQ-1:0]                       req_i,      // one bit per requester
  input  logic                                   ack_i,      // granted transfer completes
  output logic [N_REQ-1:0]                       gnt_o,      // one-hot grant
  output logic [((N_REQ > 1) ? $clog2(N_REQ) : 1)-1:0] gnt_idx_o
);

  localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

  logic [IDX_W-1:0] ptr_q;                                    // highest priority index
  logic             lock_q;                                   // grant held until ack
  logic [IDX_W-1:0] lock_idx_q;
  logic [IDX_W-1:0] pick_idx;                                 // search result
  logic             found;
  logic [IDX_W-1:0] win_idx;
  logic             gnt_valid;

  // first requester at or after the pointer
  always_comb
  begin
    int unsigned cand;
    found    = 1'b0;
    pick_idx = ptr_q;
    for (int k = 0; k < N_REQ; k++)
    begin
      cand = (int'(ptr_q) + k) % N_REQ;                       // wrap around
      if (!found && req_i[cand])
      begin
        found    = 1'b1;
        pick_idx = IDX_W'(cand);
      end
    end
  end

  assign win_idx   = lock_q ? lock_idx_q : pick_idx;          // held grant wins
  assign gnt_valid = lock_q | found;
  assign gnt_o     = gnt_valid ? (N_REQ'(1) << win_idx) : '0;
  assign gnt_idx_o = win_idx;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end
    else if (gnt_valid)
    begin
      if (ack_i)
      begin
        lock_q <= 1'b0;                                       // release, rotate past winner
        ptr_q  <= (win_idx == IDX_W'(N_REQ - 1)) ? '0 : win_idx + 1'b1;
      end
      else
      begin
        lock_q     <= 1'b1;                                   // freeze until done
        lock_idx_q <= win_idx;
      end
    end
  end

  // a grant without ack is still the same grant one cycle later
  a_gnt_hold : assert property (@(posedge clk) disable iff (reset_i)
                                (|gnt_o) && !ack_i |=> $stable(gnt_o))
    else $error("Fail: rr_arbiter dropped a grant before ack at %0t", $time);

endmodule

//--- hdl/ar_addr_decoder.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module ar_addr_decoder
  import xbar_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         reset_i,
  input  ar_in_t                                       ar_i,          // from the master
  input  logic                                         ar_valid_i,
  output logic                                         ar_ready_o,
  input  map_rule_t [`XBAR_N_REGION-1:0][`XBAR_N_INIT-1:0] map_i,
  input  logic [`XBAR_N_INIT-1:0]                      conn_i,        // reachable slaves
  output logic [`XBAR_N_INIT-1:0]                      route_valid_o, // toward request blocks
  input  logic [`XBAR_N_INIT-1:0]                      route_ready_i,
  output r_in_t                                        err_beat_o,    // local DECERR beats
  output logic                                         err_valid_o,
  input  logic                                         err_ready_i
);

  logic [`XBAR_N_INIT-1:0]  hit;                 // rule match per initiator port
  logic [`XBAR_N_INIT-1:0]  sel;                 // lowest matching port only
  logic                     miss;
  logic                     err_take;            // unmapped address accepted
  logic                     err_busy_q;          // DECERR burst pending
  logic                     err_last;
  logic [`XBAR_ID_IN_W-1:0] err_id_q;
  logic [`XBAR_LEN_W-1:0]   err_len_q;
  logic [`XBAR_LEN_W-1:0]   err_cnt_q;           // beats already given

  // ---------------------------------------------------------------------------
  // address match
  // ---------------------------------------------------------------------------
  always_comb
  begin
    hit = '0;
    for (int i = 0; i < `XBAR_N_INIT; i++)
    begin
      for (int r = 0; r < `XBAR_N_REGION; r++)
      begin
        if (conn_i[i] && map_i[r][i].enable &&
            ar_i.addr >= map_i[r][i].start_addr && ar_i.addr <= map_i[r][i].end_addr)
          hit[i] = 1'b1;
      end
    end
  end

  assign sel  = hit & (~hit + 1'b1);             // isolate lowest set bit
  assign miss = ~|hit;

  // no new address of any kind while an error burst drains
  assign route_valid_o = (ar_valid_i && !err_busy_q) ? sel : '0;
  assign ar_ready_o    = !err_busy_q && (miss || |(sel & route_ready_i));
  assign err_take      = ar_valid_i && ar_ready_o && miss;

  // ---------------------------------------------------------------------------
  // DECERR generator
  // ---------------------------------------------------------------------------
  assign err_valid_o = err_busy_q;
  assign err_last    = (err_cnt_q == err_len_q);

  always_comb
  begin
    err_beat_o      = '0;                        // rdata stays zero
    err_beat_o.id   = err_id_q;
    err_beat_o.resp = `XBAR_RESP_DECERR;
    err_beat_o.last = err_last;
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      err_busy_q <= 1'b0;
      err_cnt_q  <= '0;
    end
    else if (err_take)
    begin
      err_busy_q <= 1'b1;                        // first beat next cycle
      err_cnt_q  <= '0;
    end
    else if (err_valid_o && err_ready_i)
    begin
      err_busy_q <= !err_last;
      err_cnt_q  <= err_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (err_take)
    begin
      err_id_q  <= ar_i.id;
      err_len_q <= ar_i.len;
    end
  end

  // a pending error beat must survive back-pressure, no new address may reload it
  a_err_hold : assert property (@(posedge clk) disable iff (reset_i)
                                err_valid_o && !err_ready_i |=>
                                err_valid_o && $stable(err_beat_o))
    else $error("Fail: DECERR beat changed under back-pressure at %0t", $time);

endmodule

//--- hdl/ar_request_block.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module ar_request_block
  import xbar_pkg::*;
(
  input  logic                              clk,
  input  logic                              reset_i,
  input  ar_in_t [`XBAR_N_TARG-1:0]         ar_i,           // every target's address
  input  logic [`XBAR_N_TARG-1:0]           ar_valid_i,     // routed to this port
  output logic [`XBAR_N_TARG-1:0]           ar_ready_o,
  output ar_out_t                           m_ar_o,         // initiator port
  output logic                              m_ar_valid_o,
  input  logic                              m_ar_ready_i
);

  localparam int TIDX_W = `XBAR_ID_OUT_W - `XBAR_ID_IN_W;

  logic [`XBAR_N_TARG-1:0] gnt;
  logic [TIDX_W-1:0]       gnt_idx;               // also the id prefix
  logic                    m_ar_hs;

  assign m_ar_hs = m_ar_valid_o && m_ar_ready_i;   // frees the arbiter

  rr_arbiter
  #(
    .N_REQ     ( `XBAR_N_TARG )
  )
  arbiter_i
  (
    .clk       ( clk          ),
    .reset_i   ( reset_i      ),
    .req_i     ( ar_valid_i   ),
    .ack_i     ( m_ar_hs      ),
    .gnt_o     ( gnt          ),
    .gnt_idx_o ( gnt_idx      )
  );

  // ---------------------------------------------------------------------------
  // address mux and id extension
  // ---------------------------------------------------------------------------
  always_comb
  begin
    m_ar_o.id   = {gnt_idx, ar_i[gnt_idx].id};     // target index on top
    m_ar_o.addr = ar_i[gnt_idx].addr;
    m_ar_o.len  = ar_i[gnt_idx].len;
  end

  assign m_ar_valid_o = |(gnt & ar_valid_i);
  assign ar_ready_o   = gnt & {`XBAR_N_TARG{m_ar_ready_i}};  // only the winner sees ready

endmodule

//--- hdl/r_response_block.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module r_response_block
  import xbar_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset_i,
  input  r_out_t [`XBAR_N_INIT-1:0]      r_i,            // beats from every slave
  input  logic [`XBAR_N_INIT-1:0]        r_valid_i,      // only beats for this target
  output logic [`XBAR_N_INIT-1:0]        r_ready_o,
  input  r_in_t                          err_beat_i,     // same-port DECERR generator
  input  logic                           err_valid_i,
  output logic                           err_ready_o,
  output r_in_t                          s_r_o,          // toward the master
  output logic                           s_r_valid_o,
  input  logic                           s_r_ready_i
);

  localparam int N_SRC = `XBAR_N_INIT + 1;        // slaves plus DECERR source
  localparam int SIDX_W = $clog2(N_SRC);

  r_in_t [N_SRC-1:0]  src_beat;
  logic [N_SRC-1:0]   src_valid;
  logic [N_SRC-1:0]   gnt;
  logic [N_SRC-1:0]   src_ready;
  logic [SIDX_W-1:0]  gnt_idx;
  logic               burst_done;                 // last beat handshaken

  // ---------------------------------------------------------------------------
  // source beats with the target index stripped
  // ---------------------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < `XBAR_N_INIT; i++)
    begin
      src_beat[i].id   = r_i[i].id[`XBAR_ID_IN_W-1:0];
      src_beat[i].data = r_i[i].data;
      src_beat[i].resp = r_i[i].resp;
      src_beat[i].last = r_i[i].last;
    end
    src_beat[N_SRC-1] = err_beat_i;               // error source sits last
  end

  assign src_valid  = {err_valid_i, r_valid_i};
  assign burst_done = s_r_valid_o && s_r_ready_i && s_r_o.last;

  // grant is the burst lock, held from first beat to rlast
  rr_arbiter
  #(
    .N_REQ     ( N_SRC      )
  )
  arbiter_i
  (
    .clk       ( clk        ),
    .reset_i   ( reset_i    ),
    .req_i     ( src_valid  ),
    .ack_i     ( burst_done ),
    .gnt_o     ( gnt        ),
    .gnt_idx_o ( gnt_idx    )
  );

  assign s_r_o       = src_beat[gnt_idx];
  assign s_r_valid_o = |(gnt & src_valid);
  assign src_ready   = gnt & {N_SRC{s_r_ready_i}};  // held source waits on master
  assign r_ready_o   = src_ready[`XBAR_N_INIT-1:0];
  assign err_ready_o = src_ready[N_SRC-1];

  // needs the slaves and the DECERR generator to hold their beats as well
  a_beat_stable : assert property (@(posedge clk) disable iff (reset_i)
                                   s_r_valid_o && !s_r_ready_i |=>
                                   s_r_valid_o && $stable(s_r_o))
    else $error("Fail: read beat changed under back-pressure at %0t", $time);

endmodule

//--- hdl/axi_read_node.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module axi_read_node
  import xbar_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         reset_i,
  // target ports, upstream masters
  input  ar_in_t [`XBAR_N_TARG-1:0]                    targ_ar_i,
  input  logic [`XBAR_N_TARG-1:0]                      targ_ar_valid_i,
  output logic [`XBAR_N_TARG-1:0]                      targ_ar_ready_o,
  output r_in_t [`XBAR_N_TARG-1:0]                     targ_r_o,
  output logic [`XBAR_N_TARG-1:0]                      targ_r_valid_o,
  input  logic [`XBAR_N_TARG-1:0]                      targ_r_ready_i,
  // initiator ports, downstream slaves
  output ar_out_t [`XBAR_N_INIT-1:0]                   init_ar_o,
  output logic [`XBAR_N_INIT-1:0]                      init_ar_valid_o,
  input  logic [`XBAR_N_INIT-1:0]                      init_ar_ready_i,
  input  r_out_t [`XBAR_N_INIT-1:0]                    init_r_i,
  input  logic [`XBAR_N_INIT-1:0]                      init_r_valid_i,
  output logic [`XBAR_N_INIT-1:0]                      init_r_ready_o,
  // memory map and connectivity
  input  map_rule_t [`XBAR_N_REGION-1:0][`XBAR_N_INIT-1:0] map_i,
  input  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0]    conn_i
);

  localparam int TIDX_W = `XBAR_ID_OUT_W - `XBAR_ID_IN_W;

  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0] arvalid_int;     // decoder view
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0] arvalid_rev;     // request block view
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0] arready_int;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0] arready_rev;
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0] rvalid_route;    // beat valid per target
  logic [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0] rready_int;
  logic [`XBAR_N_INIT-1:0][`XBAR_N_TARG-1:0] rready_rev;
  r_in_t [`XBAR_N_TARG-1:0]                  err_beat;
  logic [`XBAR_N_TARG-1:0]                   err_valid;
  logic [`XBAR_N_TARG-1:0]                   err_ready;

  // ---------------------------------------------------------------------------
  // matrix transposes and id-based beat routing
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : g_xpose
    for (genvar t = 0; t < `XBAR_N_TARG; t++)
    begin : g_targ
      assign arvalid_rev[i][t] = arvalid_int[t][i];
      assign arready_rev[t][i] = arready_int[i][t];
      assign rready_rev[i][t]  = rready_int[t][i];
      assign rvalid_route[t][i] = init_r_valid_i[i] &&
        (init_r_i[i].id[`XBAR_ID_OUT_W-1:`XBAR_ID_IN_W] == TIDX_W'(t));  // upper id bit
    end
    assign init_r_ready_o[i] = |rready_rev[i];                 // only the owner answers
  end

  // ---------------------------------------------------------------------------
  // per target port decode and response
  // ---------------------------------------------------------------------------
  for (genvar t = 0; t < `XBAR_N_TARG; t++)
  begin : g_targ_port
    ar_addr_decoder decoder_i
    (
      .clk           ( clk                ),
      .reset_i       ( reset_i            ),
      .ar_i          ( targ_ar_i[t]       ),
      .ar_valid_i    ( targ_ar_valid_i[t] ),
      .ar_ready_o    ( targ_ar_ready_o[t] ),
      .map_i         ( map_i              ),
      .conn_i        ( conn_i[t]          ),
      .route_valid_o ( arvalid_int[t]     ),
      .route_ready_i ( arready_rev[t]     ),
      .err_beat_o    ( err_beat[t]        ),
      .err_valid_o   ( err_valid[t]       ),
      .err_ready_i   ( err_ready[t]       )
    );

    r_response_block resp_i
    (
      .clk           ( clk                ),
      .reset_i       ( reset_i            ),
      .r_i           ( init_r_i           ),
      .r_valid_i     ( rvalid_route[t]    ),
      .r_ready_o     ( rready_int[t]      ),
      .err_beat_i    ( err_beat[t]        ),     // local errors stay on this port
      .err_valid_i   ( err_valid[t]       ),
      .err_ready_o   ( err_ready[t]       ),
      .s_r_o         ( targ_r_o[t]        ),
      .s_r_valid_o   ( targ_r_valid_o[t]  ),
      .s_r_ready_i   ( targ_r_ready_i[t]  )
    );
  end

  // ---------------------------------------------------------------------------
  // per initiator port request arbitration
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : g_init_port
    ar_request_block req_i
    (
      .clk           ( clk                ),
      .reset_i       ( reset_i            ),
      .ar_i          ( targ_ar_i          ),
      .ar_valid_i    ( arvalid_rev[i]     ),
      .ar_ready_o    ( arready_int[i]     ),
      .m_ar_o        ( init_ar_o[i]       ),
      .m_ar_valid_o  ( init_ar_valid_o[i] ),
      .m_ar_ready_i  ( init_ar_ready_i[i] )
    );
  end

endmodule

//--- verification/tb_slave_model.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module tb_slave_model
  import xbar_pkg::*;
#(
  parameter int PORT = 0                          // goes into data bit 63
)
(
  input  logic       clk,
  input  logic       reset_i,
  input  ar_out_t    ar_i,                        // from the initiator port
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  output r_out_t     r_o,                         // beats back into the node
  output logic       r_valid_o,
  input  logic       r_ready_i,
  input  logic [1:0] stall_i                      // [0] holds arready, [1] delays a new beat
);

  ar_out_t                pending[$];             // accepted reads, oldest first
  logic [`XBAR_LEN_W-1:0] beat;                   // beat index in the head burst
  logic                   held;                   // beat shown and not yet taken
  logic                   in_reset;
  logic                   take_ar;
  logic                   give_r;

  initial
  begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    beat       = '0;
  end

  always @(posedge clk)
  begin
    in_reset = reset_i;                           // everything sampled at the edge
    take_ar  = !stall_i[0];
    give_r   = !stall_i[1];
    held     = r_valid_o && !r_ready_i;
    if (in_reset)
    begin
      pending.delete();
      beat = '0;
    end
    else
    begin
      if (ar_valid_i && ar_ready_o)
        pending.push_back(ar_i);
      if (r_valid_o && r_ready_i)
      begin
        if (beat == pending[0].len)               // burst done, move to the next
        begin
          void'(pending.pop_front());
          beat = '0;
        end
        else
          beat = beat + 1'b1;
      end
    end
    #1;
    ar_ready_o = !in_reset && take_ar;
    if (!held)                                    // a shown beat stays until taken
      r_valid_o = !in_reset && (pending.size() != 0) && give_r;
    if (pending.size() != 0)
    begin
      r_o.id   = pending[0].id;
      r_o.data = `XBAR_DATA_W'(pending[0].addr) + (`XBAR_DATA_W'(beat) << 3);
      r_o.data[`XBAR_DATA_W-1] = 1'(PORT);        // port tag on top
      r_o.resp = `XBAR_RESP_OKAY;
      r_o.last = (beat == pending[0].len);
    end
  end

endmodule

//--- verification/tb_axi_read_node.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module tb_axi_read_node
  import xbar_pkg::*;
();

  localparam int          ERR_PORT    = `XBAR_N_INIT;         // local DECERR answer
  localparam int          ID_NUM      = 1 << `XBAR_ID_IN_W;
  localparam int          WAIT_LIMIT  = 2000;
  localparam int          DRAIN_LIMIT = 5000;
  localparam logic [31:0] SEED        = 32'h0478_9075;

  logic                                          clk;
  logic                                          reset_i;
  ar_in_t    [`XBAR_N_TARG-1:0]                  targ_ar;
  logic      [`XBAR_N_TARG-1:0]                  targ_ar_valid;
  logic      [`XBAR_N_TARG-1:0]                  targ_ar_ready;
  r_in_t     [`XBAR_N_TARG-1:0]                  targ_r;
  logic      [`XBAR_N_TARG-1:0]                  targ_r_valid;
  logic      [`XBAR_N_TARG-1:0]                  targ_r_ready;
  ar_out_t   [`XBAR_N_INIT-1:0]                  init_ar;
  logic      [`XBAR_N_INIT-1:0]                  init_ar_valid;
  logic      [`XBAR_N_INIT-1:0]                  init_ar_ready;
  r_out_t    [`XBAR_N_INIT-1:0]                  init_r;
  logic      [`XBAR_N_INIT-1:0]                  init_r_valid;
  logic      [`XBAR_N_INIT-1:0]                  init_r_ready;
  map_rule_t [`XBAR_N_REGION-1:0][`XBAR_N_INIT-1:0] mem_map;
  logic      [`XBAR_N_TARG-1:0][`XBAR_N_INIT-1:0] conn;
  logic      [`XBAR_N_INIT-1:0][1:0]             slave_stall;
  logic                                          stall_en;    // random back-pressure on
  logic      [31:0]                              stall_state;
  logic      [31:0]                              stim_state [`XBAR_N_TARG];
  logic      [`XBAR_ID_IN_W-1:0]                 next_id [`XBAR_N_TARG];

  // ---------------------------------------------------------------------------
  // expected bursts per master, indexed by id since ids in flight are unique
  // ---------------------------------------------------------------------------
  logic                     exp_busy [`XBAR_N_TARG][ID_NUM];
  logic [`XBAR_ADDR_W-1:0]  exp_addr [`XBAR_N_TARG][ID_NUM];
  logic [`XBAR_LEN_W-1:0]   exp_len  [`XBAR_N_TARG][ID_NUM];
  logic [`XBAR_LEN_W-1:0]   exp_cnt  [`XBAR_N_TARG][ID_NUM];    // beats seen so far
  int                       exp_port [`XBAR_N_TARG][ID_NUM];
  logic                     open_q   [`XBAR_N_TARG];            // burst under way
  logic [`XBAR_ID_IN_W-1:0] open_id  [`XBAR_N_TARG];
  logic [`XBAR_N_TARG-1:0]  fwd_ok;
  logic [`XBAR_N_TARG-1:0]  beat_ok;
  logic [`XBAR_N_INIT-1:0]  origin_ok;

  always #5 clk = ~clk;

  axi_read_node axi_read_node_i
  (
    .clk             ( clk           ),
    .reset_i         ( reset_i       ),
    .targ_ar_i       ( targ_ar       ),
    .targ_ar_valid_i ( targ_ar_valid ),
    .targ_ar_ready_o ( targ_ar_ready ),
    .targ_r_o        ( targ_r        ),
    .targ_r_valid_o  ( targ_r_valid  ),
    .targ_r_ready_i  ( targ_r_ready  ),
    .init_ar_o       ( init_ar       ),
    .init_ar_valid_o ( init_ar_valid ),
    .init_ar_ready_i ( init_ar_ready ),
    .init_r_i        ( init_r        ),
    .init_r_valid_i  ( init_r_valid  ),
    .init_r_ready_o  ( init_r_ready  ),
    .map_i           ( mem_map       ),
    .conn_i          ( conn          )
  );

  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : g_slave
    tb_slave_model #( .PORT ( i ) ) slave_i
    (
      .clk        ( clk              ),
      .reset_i    ( reset_i          ),
      .ar_i       ( init_ar[i]       ),
      .ar_valid_i ( init_ar_valid[i] ),
      .ar_ready_o ( init_ar_ready[i] ),
      .r_o        ( init_r[i]        ),
      .r_valid_o  ( init_r_valid[i]  ),
      .r_ready_i  ( init_r_ready[i]  ),
      .stall_i    ( slave_stall[i]   )
    );
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory map as set below, target 1 reaches initiator 0 only
  function automatic int expected_port(input int t, input logic [31:0] addr);
    if (addr <= 32'h0FFF_FFFF)
      return 0;
    if (addr >= 32'h1000_0000 && addr <= 32'h1FFF_FFFF && t == 0)
      return 1;
    return ERR_PORT;
  endfunction

  function automatic logic any_busy();
    logic busy;
    busy = 1'b0;
    for (int t = 0; t < `XBAR_N_TARG; t++)
      for (int n = 0; n < ID_NUM; n++)
        busy = busy | exp_busy[t][n];
    return busy;
  endfunction

  task report_mismatch(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task give_up(input string why);
    $display("Timeout: %s", why);
    $display("TEST FAILED");
    $fatal(1, "no progress");
  endtask

  // ---------------------------------------------------------------------------
  // expected values, from the map and the slave data rule
  // ---------------------------------------------------------------------------
  always_comb
  begin
    int      port;
    int      src;
    ar_out_t want;
    for (int t = 0; t < `XBAR_N_TARG; t++)
    begin
      port      = expected_port(t, targ_ar[t].addr);
      want.id   = {1'(t), targ_ar[t].id};                       // target index on top
      want.addr = targ_ar[t].addr;
      want.len  = targ_ar[t].len;
      fwd_ok[t] = 1'b1;
      if (targ_ar_valid[t] && targ_ar_ready[t] && port != ERR_PORT)
        fwd_ok[t] = init_ar_valid[port] && init_ar_ready[port] && init_ar[port] == want;
    end
    for (int i = 0; i < `XBAR_N_INIT; i++)
    begin
      src          = int'(init_ar[i].id[`XBAR_ID_OUT_W-1]);
      origin_ok[i] = targ_ar_valid[src] && expected_port(src, targ_ar[src].addr) == i;
    end
  end

  always_comb
  begin
    logic [`XBAR_ID_IN_W-1:0] rid;
    logic [`XBAR_DATA_W-1:0]  want_data;
    logic [1:0]               want_resp;
    for (int t = 0; t < `XBAR_N_TARG; t++)
    begin
      rid = targ_r[t].id;
      if (exp_port[t][rid] == ERR_PORT)
      begin
        want_data = '0;                                         // DECERR beats carry zero
        want_resp = `XBAR_RESP_DECERR;
      end
      else
      begin
        want_data = `XBAR_DATA_W'(exp_addr[t][rid]) + (`XBAR_DATA_W'(exp_cnt[t][rid]) << 3);
        want_data[`XBAR_DATA_W-1] = 1'(exp_port[t][rid]);
        want_resp = `XBAR_RESP_OKAY;
      end
      beat_ok[t] = exp_busy[t][rid] && (!open_q[t] || open_id[t] == rid) &&
                   targ_r[t].data == want_data && targ_r[t].resp == want_resp &&
                   targ_r[t].last == (exp_cnt[t][rid] == exp_len[t][rid]);
    end
  end

  for (genvar t = 0; t < `XBAR_N_TARG; t++)
  begin : g_track
    always @(posedge clk)
    begin
      if (!reset_i && targ_ar_valid[t] && targ_ar_ready[t])
      begin
        exp_busy[t][targ_ar[t].id] <= 1'b1;
        exp_addr[t][targ_ar[t].id] <= targ_ar[t].addr;
        exp_len[t][targ_ar[t].id]  <= targ_ar[t].len;
        exp_port[t][targ_ar[t].id] <= expected_port(t, targ_ar[t].addr);
        exp_cnt[t][targ_ar[t].id]  <= '0;
      end
      if (!reset_i && targ_r_valid[t] && targ_r_ready[t])
      begin
        exp_cnt[t][targ_r[t].id] <= exp_cnt[t][targ_r[t].id] + 1'b1;
        open_q[t]                <= !targ_r[t].last;           // no other id until rlast
        open_id[t]               <= targ_r[t].id;
        if (targ_r[t].last)
          exp_busy[t][targ_r[t].id] <= 1'b0;
      end
    end

    a_ar_forward : assert property (@(posedge clk) disable iff (reset_i) fwd_ok[t])
      else report_mismatch($sformatf("target %0d read address not forwarded as sent", t));
    a_r_beat : assert property (@(posedge clk) disable iff (reset_i)
                                targ_r_valid[t] && targ_r_ready[t] |-> beat_ok[t])
      else report_mismatch($sformatf("target %0d got a wrong or unexpected beat", t));
  end

  for (genvar i = 0; i < `XBAR_N_INIT; i++)
  begin : g_origin
    a_ar_origin : assert property (@(posedge clk) disable iff (reset_i)
                                   init_ar_valid[i] |-> origin_ok[i])
      else report_mismatch($sformatf("initiator %0d shows a read nobody routed there", i));
  end

  // back-pressure pattern, new every cycle
  always @(posedge clk)
  begin
    #1;
    stall_state = next_rand(stall_state);
    for (int t = 0; t < `XBAR_N_TARG; t++)
      targ_r_ready[t] = !(stall_en && stall_state[16+t] && stall_state[18+t]);
    for (int i = 0; i < `XBAR_N_INIT; i++)
    begin
      slave_stall[i][0] = stall_en && stall_state[24+i] && stall_state[26+i];
      slave_stall[i][1] = stall_en && stall_state[28+i] && stall_state[30+i];
    end
  end

  task automatic issue_read(input int t, input logic [31:0] addr, input logic [7:0] len);
    logic [`XBAR_ID_IN_W-1:0] id;
    int                       waited;
    id         = next_id[t];
    next_id[t] = next_id[t] + 1'b1;
    waited     = 0;
    while (exp_busy[t][id])                                     // keep ids unique in flight
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT)
        give_up("a read id stayed in flight too long");
    end
    targ_ar[t].id      = id;
    targ_ar[t].addr    = addr;
    targ_ar[t].len     = len;
    targ_ar_valid[t]   = 1'b1;
    waited             = 0;
    @(posedge clk);
    while (!targ_ar_ready[t])
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        give_up("a read address was never accepted");
      @(posedge clk);
    end
    #1;
    targ_ar_valid[t] = 1'b0;
  endtask

  task automatic issue_batch(input int t, input int count, input bit init0_only);
    logic [31:0] rnd;
    logic [31:0] addr;
    for (int n = 0; n < count; n++)
    begin
      stim_state[t] = next_rand(stim_state[t]);
      rnd           = stim_state[t];
      addr          = {8'h00, rnd[23:3], 3'b000};
      if (!init0_only && rnd[31:30] == 2'd1)
        addr[31:28] = 4'h1;                                     // initiator 1 window
      else if (!init0_only && rnd[31:30] == 2'd2)
        addr[31:28] = 4'h7;                                     // hits no rule
      issue_read(t, addr, {5'd0, rnd[26:24]});
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (any_busy())
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > DRAIN_LIMIT)
        give_up("expected read data never arrived in full");
    end
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial
  begin
    clk           = 1'b0;
    reset_i       = 1'b1;
    targ_ar       = '0;
    targ_ar_valid = '0;
    targ_r_ready  = '0;
    slave_stall   = '0;
    stall_en      = 1'b0;
    stall_state   = SEED;
    for (int t = 0; t < `XBAR_N_TARG; t++)
    begin
      stim_state[t] = SEED ^ (t + 1);
      next_id[t]    = '0;
      open_q[t]     = 1'b0;
      open_id[t]    = '0;
      for (int n = 0; n < ID_NUM; n++)
        exp_busy[t][n] = 1'b0;
    end
    mem_map       = '0;                                         // all rules cleared first
    mem_map[0][0] = '{start_addr: 32'h0000_0000, end_addr: 32'h0FFF_FFFF, enable: 1'b1};
    mem_map[0][1] = '{start_addr: 32'h1000_0000, end_addr: 32'h1FFF_FFFF, enable: 1'b1};
    // region 1 disabled, its bounds cover the windows used for unmapped reads
    mem_map[1][0] = '{start_addr: 32'h3000_0000, end_addr: 32'h3FFF_FFFF, enable: 1'b0};
    mem_map[1][1] = '{start_addr: 32'h7000_0000, end_addr: 32'h7FFF_FFFF, enable: 1'b0};
    conn[0]       = 2'b11;
    conn[1]       = 2'b01;
    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;

    issue_read(0, 32'h0000_1000, 8'd3);                         // both mapped windows
    issue_read(0, 32'h1000_2000, 8'd0);
    wait_idle();

    issue_read(0, 32'h3000_0000, 8'd2);                         // no rule matches
    issue_read(1, 32'h1000_0040, 8'd1);                         // not connected
    wait_idle();

    fork                                                        // both on initiator 0
      issue_batch(0, 8, 1'b1);
      issue_batch(1, 8, 1'b1);
    join
    wait_idle();

    stall_en = 1'b1;
    fork
      issue_batch(0, 24, 1'b0);
      issue_batch(1, 24, 1'b0);
    join
    wait_idle();

    $display("TEST OK");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/xbar_pkg.sv
hdl/rr_arbiter.sv
hdl/ar_addr_decoder.sv
hdl/ar_request_block.sv
hdl/r_response_block.sv
hdl/axi_read_node.sv
verification/tb_slave_model.sv
verification/tb_axi_read_node.sv

//--- Makefile
SIM  := obj_dir/Vtb_axi_read_node
SRCS := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
	  --top-module tb_axi_read_node --Mdir obj_dir

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
